// ==== common/bpu_pkg.sv ====
// branch-kind codes, table sizes and execute buffer sizes
package bpu_pkg;

    // word address width
    localparam int PC_W   = 30;
    localparam int KIND_W = 3;

    // resolved branch kinds
    localparam logic [KIND_W-1:0] KIND_NOT_JUMP = 3'd0;
    localparam logic [KIND_W-1:0] KIND_DIRECT   = 3'd1;
    localparam logic [KIND_W-1:0] KIND_CALL     = 3'd2;
    localparam logic [KIND_W-1:0] KIND_RET      = 3'd3;
    localparam logic [KIND_W-1:0] KIND_INDIRECT = 3'd4;
    localparam logic [KIND_W-1:0] KIND_OTHER    = 3'd5;

    // execute buffer
    localparam int EXB_DEPTH = 8;
    localparam int EXB_PTR_W = $clog2(EXB_DEPTH);
    localparam int EXB_CNT_W = $clog2(EXB_DEPTH + 1);

    // pattern history table of 64 counters
    localparam int PHT_IDX_W = 6;
    localparam int PHT_SIZE  = 1 << PHT_IDX_W;

    // branch target buffer of 32 entries
    localparam int BTB_IDX_W = 5;
    localparam int BTB_SIZE  = 1 << BTB_IDX_W;
    localparam int BTB_TAG_W = PC_W - BTB_IDX_W;

    // saturation limits of the 2-bit counters
    localparam logic [1:0] CNT_MAX  = 2'd3;
    localparam logic [1:0] CNT_MIN  = 2'd0;
    localparam logic [1:0] CNT_INIT = 2'd1; // weakly not taken

endpackage

// ==== hdl/pht.sv ====
// pattern history table of 2-bit saturating counters with registered lookup
`timescale 1ns/1ps

module pht (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        upd_valid,
    input  logic [bpu_pkg::PC_W-1:0]    upd_pc,
    input  logic                        upd_taken,
    input  logic [1:0]                  upd_counter,
    input  logic [bpu_pkg::PC_W-1:0]    lookup_pc,
    output logic [1:0]                  lookup_counter
);

    logic [1:0]                   cnt [bpu_pkg::PHT_SIZE];
    logic [bpu_pkg::PHT_IDX_W-1:0] upd_idx;
    logic [bpu_pkg::PHT_IDX_W-1:0] lookup_idx;
    logic [1:0]                   cnt_next;

    assign upd_idx    = upd_pc[bpu_pkg::PHT_IDX_W-1:0];
    assign lookup_idx = lookup_pc[bpu_pkg::PHT_IDX_W-1:0];

    // step from the counter the prediction used so no table read is needed
    always_comb begin
        if (upd_taken)
            cnt_next = (upd_counter == bpu_pkg::CNT_MAX) ? upd_counter : upd_counter + 2'd1;
        else
            cnt_next = (upd_counter == bpu_pkg::CNT_MIN) ? upd_counter : upd_counter - 2'd1;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < bpu_pkg::PHT_SIZE; i++)
                cnt[i] <= bpu_pkg::CNT_INIT;
        end else if (upd_valid) begin
            cnt[upd_idx] <= cnt_next;
        end
    end

    // same-edge write is not visible here
    always_ff @(posedge clk) begin
        lookup_counter <= cnt[lookup_idx];
    end

endmodule

// ==== hdl/btb.sv ====
// direct-mapped branch target buffer with tag compare and registered lookup
`timescale 1ns/1ps

module btb (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        upd_valid,
    input  logic                        upd_taken,
    input  logic [bpu_pkg::PC_W-1:0]    upd_pc,
    input  logic [bpu_pkg::PC_W-1:0]    upd_target,
    input  logic [bpu_pkg::KIND_W-1:0]  upd_kind,
    input  logic [bpu_pkg::PC_W-1:0]    lookup_pc,
    output logic                        lookup_hit,
    output logic [bpu_pkg::PC_W-1:0]    lookup_target,
    output logic [bpu_pkg::KIND_W-1:0]  lookup_kind
);

    logic                           ent_valid  [bpu_pkg::BTB_SIZE];
    logic [bpu_pkg::BTB_TAG_W-1:0]  ent_tag    [bpu_pkg::BTB_SIZE];
    logic [bpu_pkg::PC_W-1:0]       ent_target [bpu_pkg::BTB_SIZE];
    logic [bpu_pkg::KIND_W-1:0]     ent_kind   [bpu_pkg::BTB_SIZE];

    logic [bpu_pkg::BTB_IDX_W-1:0]  upd_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0]  upd_tag;
    logic [bpu_pkg::BTB_IDX_W-1:0]  lookup_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0]  lookup_tag;
    logic                           wr_en;

    assign upd_idx    = upd_pc[bpu_pkg::BTB_IDX_W-1:0];
    assign upd_tag    = upd_pc[bpu_pkg::PC_W-1:bpu_pkg::BTB_IDX_W];
    assign lookup_idx = lookup_pc[bpu_pkg::BTB_IDX_W-1:0];
    assign lookup_tag = lookup_pc[bpu_pkg::PC_W-1:bpu_pkg::BTB_IDX_W];

    // not-taken packets leave the entry alone
    assign wr_en = upd_valid & upd_taken;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < bpu_pkg::BTB_SIZE; i++)
                ent_valid[i] <= 1'b0;
            lookup_hit <= 1'b0;
        end else begin
            if (wr_en)
                ent_valid[upd_idx] <= 1'b1;
            lookup_hit <= ent_valid[lookup_idx] && (ent_tag[lookup_idx] == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_tag[upd_idx]    <= upd_tag;
            ent_target[upd_idx] <= upd_target;
            ent_kind[upd_idx]   <= upd_kind;
        end
    end

    // old entry on a same-edge write
    always_ff @(posedge clk) begin
        lookup_target <= ent_target[lookup_idx];
        lookup_kind   <= ent_kind[lookup_idx];
    end

endmodule

// ==== ex_buffer/ex_buffer.sv ====
// in-order execute buffer queue of resolved instructions, packet merge and update register
`timescale 1ns/1ps

module ex_buffer (
    input  logic                         clk,
    input  logic                         rstn,
    // lane 0, the older instruction
    input  logic                         ex_valid_0,
    input  logic [bpu_pkg::PC_W-1:0]     ex_pc_0,
    input  logic                         ex_taken_0,
    input  logic [bpu_pkg::KIND_W-1:0]   ex_kind_0,
    input  logic [bpu_pkg::PC_W-1:0]     ex_target_0,
    input  logic                         pd_taken_0,
    input  logic [bpu_pkg::PC_W-1:0]     pd_target_0,
    input  logic [1:0]                   pd_counter_0,
    input  logic                         ex_squash_0,
    // lane 1
    input  logic                         ex_valid_1,
    input  logic [bpu_pkg::PC_W-1:0]     ex_pc_1,
    input  logic                         ex_taken_1,
    input  logic [bpu_pkg::KIND_W-1:0]   ex_kind_1,
    input  logic [bpu_pkg::PC_W-1:0]     ex_target_1,
    input  logic                         pd_taken_1,
    input  logic [bpu_pkg::PC_W-1:0]     pd_target_1,
    input  logic [1:0]                   pd_counter_1,
    input  logic                         ex_squash_1,
    // merged update towards the tables
    output logic                         upd_valid,
    output logic [bpu_pkg::PC_W-1:0]     upd_pc,
    output logic                         upd_taken,
    output logic [bpu_pkg::KIND_W-1:0]   upd_kind,
    output logic [bpu_pkg::PC_W-1:0]     upd_target,
    output logic [1:0]                   upd_counter,
    output logic                         upd_mispredict
);

    logic [bpu_pkg::PC_W-1:0]     q_pc         [bpu_pkg::EXB_DEPTH];
    logic                         q_taken      [bpu_pkg::EXB_DEPTH];
    logic [bpu_pkg::KIND_W-1:0]   q_kind       [bpu_pkg::EXB_DEPTH];
    logic [bpu_pkg::PC_W-1:0]     q_target     [bpu_pkg::EXB_DEPTH];
    logic                         q_pd_taken   [bpu_pkg::EXB_DEPTH];
    logic [bpu_pkg::PC_W-1:0]     q_pd_target  [bpu_pkg::EXB_DEPTH];
    logic [1:0]                   q_pd_counter [bpu_pkg::EXB_DEPTH];
    logic                         q_squash     [bpu_pkg::EXB_DEPTH];

    logic [bpu_pkg::EXB_PTR_W-1:0] head;
    logic [bpu_pkg::EXB_PTR_W-1:0] head_b;     // second entry of a pair
    logic [bpu_pkg::EXB_PTR_W-1:0] tail;
    logic [bpu_pkg::EXB_PTR_W-1:0] tail_1;     // slot for lane 1
    logic [bpu_pkg::EXB_CNT_W-1:0] count;
    logic [1:0]                    n_push;
    logic [1:0]                    n_pop;

    logic                         a_single;
    logic                         sel_valid;
    logic [bpu_pkg::KIND_W-1:0]   a_kind;
    logic [bpu_pkg::KIND_W-1:0]   b_kind;
    logic                         m_taken;
    logic [bpu_pkg::KIND_W-1:0]   m_kind;
    logic [bpu_pkg::PC_W-1:0]     m_target;
    logic                         m_mispredict;

    assign head_b = head + 1'b1;
    assign tail_1 = ex_valid_0 ? tail + 1'b1 : tail;
    assign n_push = {1'b0, ex_valid_0} + {1'b0, ex_valid_1};

    assign a_kind = q_kind[head];
    assign b_kind = q_kind[head_b];

    // odd pc or squashed successor means a one-instruction packet
    assign a_single = q_pc[head][0] | q_squash[head];

    always_comb begin
        sel_valid = 1'b0;
        n_pop     = 2'd0;
        if (count != '0 && a_single) begin
            sel_valid = 1'b1;
            n_pop     = 2'd1;
        end else if (count >= 2) begin
            sel_valid = 1'b1;
            n_pop     = 2'd2;
        end
        // else wait for the second half of the packet
    end

    always_comb begin
        if (a_single) begin
            m_taken  = q_taken[head];
            m_kind   = a_kind;
            m_target = q_target[head];
        end else begin
            m_taken = q_taken[head] | q_taken[head_b];
            if (a_kind == bpu_pkg::KIND_DIRECT || b_kind == bpu_pkg::KIND_DIRECT)
                m_kind = bpu_pkg::KIND_DIRECT;
            else if (a_kind == bpu_pkg::KIND_CALL || b_kind == bpu_pkg::KIND_CALL)
                m_kind = bpu_pkg::KIND_CALL;
            else if (a_kind == bpu_pkg::KIND_RET || b_kind == bpu_pkg::KIND_RET)
                m_kind = bpu_pkg::KIND_RET;
            else if (a_kind == bpu_pkg::KIND_INDIRECT || b_kind == bpu_pkg::KIND_INDIRECT)
                m_kind = bpu_pkg::KIND_INDIRECT;
            else if (a_kind == bpu_pkg::KIND_OTHER || b_kind == bpu_pkg::KIND_OTHER)
                m_kind = bpu_pkg::KIND_OTHER;
            else
                m_kind = bpu_pkg::KIND_NOT_JUMP;
            m_target = q_taken[head] ? q_target[head] : q_target[head_b];
        end
        // wrong direction, or right direction with wrong target
        m_mispredict = (q_pd_taken[head] != m_taken) |
                       (q_pd_taken[head] & m_taken & (q_pd_target[head] != m_target));
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            upd_valid <= 1'b0;
        end else begin
            head      <= head + n_pop;
            tail      <= tail + n_push;
            count     <= count + n_push - n_pop;
            upd_valid <= sel_valid;
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (ex_valid_0) begin
            q_pc[tail]         <= ex_pc_0;
            q_taken[tail]      <= ex_taken_0;
            q_kind[tail]       <= ex_kind_0;
            q_target[tail]     <= ex_target_0;
            q_pd_taken[tail]   <= pd_taken_0;
            q_pd_target[tail]  <= pd_target_0;
            q_pd_counter[tail] <= pd_counter_0;
            q_squash[tail]     <= ex_squash_0;
        end
        if (ex_valid_1) begin
            q_pc[tail_1]         <= ex_pc_1;
            q_taken[tail_1]      <= ex_taken_1;
            q_kind[tail_1]       <= ex_kind_1;
            q_target[tail_1]     <= ex_target_1;
            q_pd_taken[tail_1]   <= pd_taken_1;
            q_pd_target[tail_1]  <= pd_target_1;
            q_pd_counter[tail_1] <= pd_counter_1;
            q_squash[tail_1]     <= ex_squash_1;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            upd_pc         <= q_pc[head];
            upd_taken      <= m_taken;
            upd_kind       <= m_kind;
            upd_target     <= m_target;
            upd_counter    <= q_pd_counter[head]; // head counter only
            upd_mispredict <= m_mispredict;
        end
    end

endmodule

// ==== hdl/bpu_update_top.sv ====
// predictor update path top with execute buffer, pattern history table and target buffer
`timescale 1ns/1ps

module bpu_update_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         ex_valid_0,
    input  logic [bpu_pkg::PC_W-1:0]     ex_pc_0,
    input  logic                         ex_taken_0,
    input  logic [bpu_pkg::KIND_W-1:0]   ex_kind_0,
    input  logic [bpu_pkg::PC_W-1:0]     ex_target_0,
    input  logic                         pd_taken_0,
    input  logic [bpu_pkg::PC_W-1:0]     pd_target_0,
    input  logic [1:0]                   pd_counter_0,
    input  logic                         ex_squash_0,
    input  logic                         ex_valid_1,
    input  logic [bpu_pkg::PC_W-1:0]     ex_pc_1,
    input  logic                         ex_taken_1,
    input  logic [bpu_pkg::KIND_W-1:0]   ex_kind_1,
    input  logic [bpu_pkg::PC_W-1:0]     ex_target_1,
    input  logic                         pd_taken_1,
    input  logic [bpu_pkg::PC_W-1:0]     pd_target_1,
    input  logic [1:0]                   pd_counter_1,
    input  logic                         ex_squash_1,
    input  logic [bpu_pkg::PC_W-1:0]     lookup_pc,
    output logic                         upd_valid,
    output logic [bpu_pkg::PC_W-1:0]     upd_pc,
    output logic                         upd_taken,
    output logic [bpu_pkg::KIND_W-1:0]   upd_kind,
    output logic [bpu_pkg::PC_W-1:0]     upd_target,
    output logic [1:0]                   upd_counter,
    output logic                         upd_mispredict,
    output logic [1:0]                   lookup_counter,
    output logic                         lookup_hit,
    output logic [bpu_pkg::PC_W-1:0]     lookup_target,
    output logic [bpu_pkg::KIND_W-1:0]   lookup_kind
);

    ex_buffer u_ex_buffer (
        .clk, .rstn,
        .ex_valid_0, .ex_pc_0, .ex_taken_0, .ex_kind_0, .ex_target_0,
        .pd_taken_0, .pd_target_0, .pd_counter_0, .ex_squash_0,
        .ex_valid_1, .ex_pc_1, .ex_taken_1, .ex_kind_1, .ex_target_1,
        .pd_taken_1, .pd_target_1, .pd_counter_1, .ex_squash_1,
        .upd_valid, .upd_pc, .upd_taken, .upd_kind, .upd_target,
        .upd_counter, .upd_mispredict
    );

    pht u_pht (
        .clk, .rstn,
        .upd_valid, .upd_pc, .upd_taken, .upd_counter,
        .lookup_pc,
        .lookup_counter
    );

    // trained on taken packets only
    btb u_btb (
        .clk, .rstn,
        .upd_valid, .upd_taken, .upd_pc, .upd_target, .upd_kind,
        .lookup_pc,
        .lookup_hit, .lookup_target, .lookup_kind
    );

endmodule

// ==== tests/tb_checker.sv ====
// testbench checker with reference model of execute buffer, merge rule and both tables
`timescale 1ns/1ps

module tb_checker (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         ex_valid_0,
    input  logic [bpu_pkg::PC_W-1:0]     ex_pc_0,
    input  logic                         ex_taken_0,
    input  logic [bpu_pkg::KIND_W-1:0]   ex_kind_0,
    input  logic [bpu_pkg::PC_W-1:0]     ex_target_0,
    input  logic                         pd_taken_0,
    input  logic [bpu_pkg::PC_W-1:0]     pd_target_0,
    input  logic [1:0]                   pd_counter_0,
    input  logic                         ex_squash_0,
    input  logic                         ex_valid_1,
    input  logic [bpu_pkg::PC_W-1:0]     ex_pc_1,
    input  logic                         ex_taken_1,
    input  logic [bpu_pkg::KIND_W-1:0]   ex_kind_1,
    input  logic [bpu_pkg::PC_W-1:0]     ex_target_1,
    input  logic                         pd_taken_1,
    input  logic [bpu_pkg::PC_W-1:0]     pd_target_1,
    input  logic [1:0]                   pd_counter_1,
    input  logic                         ex_squash_1,
    input  logic [bpu_pkg::PC_W-1:0]     lookup_pc,
    input  logic                         upd_valid,
    input  logic [bpu_pkg::PC_W-1:0]     upd_pc,
    input  logic                         upd_taken,
    input  logic [bpu_pkg::KIND_W-1:0]   upd_kind,
    input  logic [bpu_pkg::PC_W-1:0]     upd_target,
    input  logic [1:0]                   upd_counter,
    input  logic                         upd_mispredict,
    input  logic [1:0]                   lookup_counter,
    input  logic                         lookup_hit,
    input  logic [bpu_pkg::PC_W-1:0]     lookup_target,
    input  logic [bpu_pkg::KIND_W-1:0]   lookup_kind,
    input  logic                         end_check,
    output logic [31:0]                  mismatches,
    output logic [31:0]                  other_errors,
    output logic                         checked,
    output logic [31:0]                  model_count,
    output logic                         head_waiting
);

    // model queue with one queue per field
    logic [bpu_pkg::PC_W-1:0]      c_pc      [$];
    logic                          c_taken   [$];
    logic [bpu_pkg::KIND_W-1:0]    c_kind    [$];
    logic [bpu_pkg::PC_W-1:0]      c_target  [$];
    logic                          c_ptaken  [$];
    logic [bpu_pkg::PC_W-1:0]      c_ptarget [$];
    logic [1:0]                    c_pcnt    [$];
    logic                          c_squash  [$];

    logic [1:0]                    t_cnt   [bpu_pkg::PHT_SIZE];
    logic                          t_bv    [bpu_pkg::BTB_SIZE];
    logic [bpu_pkg::BTB_TAG_W-1:0] t_btag  [bpu_pkg::BTB_SIZE];
    logic [bpu_pkg::PC_W-1:0]      t_btgt  [bpu_pkg::BTB_SIZE];
    logic [bpu_pkg::KIND_W-1:0]    t_bkind [bpu_pkg::BTB_SIZE];

    // expected update and lookup as seen one edge later
    logic                          e_valid;
    logic [bpu_pkg::PC_W-1:0]      e_pc;
    logic                          e_taken;
    logic [bpu_pkg::KIND_W-1:0]    e_kind;
    logic [bpu_pkg::PC_W-1:0]      e_target;
    logic [1:0]                    e_counter;
    logic                          e_mispredict;
    logic                          have_lk;
    logic [1:0]                    l_cnt;
    logic                          l_hit;
    logic [bpu_pkg::PC_W-1:0]      l_tgt;
    logic [bpu_pkg::KIND_W-1:0]    l_kind;
    int                            pkt_count;
    int                            upd_seen;

    function automatic int kind_rank(input logic [bpu_pkg::KIND_W-1:0] k);
        case (k)
            bpu_pkg::KIND_DIRECT:   return 5;
            bpu_pkg::KIND_CALL:     return 4;
            bpu_pkg::KIND_RET:      return 3;
            bpu_pkg::KIND_INDIRECT: return 2;
            bpu_pkg::KIND_OTHER:    return 1;
            default:                return 0;
        endcase
    endfunction

    function automatic logic [1:0] counter_after(input logic [1:0] c, input logic up);
        int v;
        v = int'(c) + (up ? 1 : -1);
        if (v > 3)
            v = 3;
        if (v < 0)
            v = 0;
        return 2'(v);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches = mismatches + 1;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_error(input string msg);
        other_errors = other_errors + 1;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic reset_model();
        c_pc.delete();
        c_taken.delete();
        c_kind.delete();
        c_target.delete();
        c_ptaken.delete();
        c_ptarget.delete();
        c_pcnt.delete();
        c_squash.delete();
        for (int i = 0; i < bpu_pkg::PHT_SIZE; i++)
            t_cnt[i] = 2'd1; // weakly not taken
        for (int i = 0; i < bpu_pkg::BTB_SIZE; i++)
            t_bv[i] = 1'b0;
        e_valid      = 1'b0;
        have_lk      = 1'b0;
        pkt_count    = 0;
        upd_seen     = 0;
        mismatches   = 0;
        other_errors = 0;
        checked      = 1'b0;
        model_count  = 0;
        head_waiting = 1'b0;
    endtask

    task automatic check_outputs();
        if (upd_valid === 1'b1)
            upd_seen++;
        compare("upd_valid", 32'(upd_valid), 32'(e_valid));
        if (e_valid) begin
            compare("upd_pc", 32'(upd_pc), 32'(e_pc));
            compare("upd_taken", 32'(upd_taken), 32'(e_taken));
            compare("upd_kind", 32'(upd_kind), 32'(e_kind));
            compare("upd_target", 32'(upd_target), 32'(e_target));
            compare("upd_counter", 32'(upd_counter), 32'(e_counter));
            compare("upd_mispredict", 32'(upd_mispredict), 32'(e_mispredict));
        end
        if (have_lk) begin
            compare("lookup_counter", 32'(lookup_counter), 32'(l_cnt));
            compare("lookup_hit", 32'(lookup_hit), 32'(l_hit));
            if (l_hit) begin
                compare("lookup_target", 32'(lookup_target), 32'(l_tgt));
                compare("lookup_kind", 32'(lookup_kind), 32'(l_kind));
            end
        end
    endtask

    // read before this edge's table write
    task automatic predict_lookup();
        logic [bpu_pkg::BTB_IDX_W-1:0] bi;
        bi      = lookup_pc[bpu_pkg::BTB_IDX_W-1:0];
        l_cnt   = t_cnt[lookup_pc[bpu_pkg::PHT_IDX_W-1:0]];
        l_hit   = t_bv[bi] && (t_btag[bi] == lookup_pc[bpu_pkg::PC_W-1:bpu_pkg::BTB_IDX_W]);
        l_tgt   = t_btgt[bi];
        l_kind  = t_bkind[bi];
        have_lk = 1'b1;
    endtask

    task automatic write_tables();
        logic [bpu_pkg::BTB_IDX_W-1:0] bi;
        bi = e_pc[bpu_pkg::BTB_IDX_W-1:0];
        if (e_valid) begin
            t_cnt[e_pc[bpu_pkg::PHT_IDX_W-1:0]] = counter_after(e_counter, e_taken);
            if (e_taken) begin
                t_bv[bi]    = 1'b1;
                t_btag[bi]  = e_pc[bpu_pkg::PC_W-1:bpu_pkg::BTB_IDX_W];
                t_btgt[bi]  = e_target;
                t_bkind[bi] = e_kind;
            end
        end
    endtask

    task automatic pop_entry();
        void'(c_pc.pop_front());
        void'(c_taken.pop_front());
        void'(c_kind.pop_front());
        void'(c_target.pop_front());
        void'(c_ptaken.pop_front());
        void'(c_ptarget.pop_front());
        void'(c_pcnt.pop_front());
        void'(c_squash.pop_front());
    endtask

    task automatic select_packet();
        int pops;
        pops    = 0;
        e_valid = 1'b0;
        if (c_pc.size() == 0)
            return;
        if (c_pc[0][0] || c_squash[0]) begin
            e_taken  = c_taken[0];
            e_kind   = c_kind[0];
            e_target = c_target[0];
            pops     = 1;
        end else if (c_pc.size() >= 2) begin
            e_taken  = c_taken[0] | c_taken[1];
            e_kind   = (kind_rank(c_kind[1]) > kind_rank(c_kind[0])) ? c_kind[1] : c_kind[0];
            e_target = c_taken[0] ? c_target[0] : c_target[1];
            pops     = 2;
        end else begin
            return; // head waits for its partner
        end
        e_pc         = c_pc[0];
        e_counter    = c_pcnt[0];
        e_mispredict = (c_ptaken[0] != e_taken) ||
                       (c_ptaken[0] && e_taken && (c_ptarget[0] != e_target));
        e_valid      = 1'b1;
        pkt_count++;
        for (int i = 0; i < pops; i++)
            pop_entry();
    endtask

    task automatic push_entry(
        input logic [bpu_pkg::PC_W-1:0]   pc,
        input logic                       taken,
        input logic [bpu_pkg::KIND_W-1:0] kind,
        input logic [bpu_pkg::PC_W-1:0]   target,
        input logic                       ptaken,
        input logic [bpu_pkg::PC_W-1:0]   ptarget,
        input logic [1:0]                 pcnt,
        input logic                       squash
    );
        c_pc.push_back(pc);
        c_taken.push_back(taken);
        c_kind.push_back(kind);
        c_target.push_back(target);
        c_ptaken.push_back(ptaken);
        c_ptarget.push_back(ptarget);
        c_pcnt.push_back(pcnt);
        c_squash.push_back(squash);
    endtask

    task automatic final_checks();
        if (c_pc.size() != 0)
            report_error($sformatf("model queue still holds %0d entries", c_pc.size()));
        if (e_valid)
            report_error("an update was still pending at the end of the run");
        if (upd_seen != pkt_count)
            report_error($sformatf("dut gave %0d updates but the model made %0d packets",
                                   upd_seen, pkt_count));
        checked = 1'b1;
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            reset_model();
        end else begin
            check_outputs();
            predict_lookup();
            write_tables();
            select_packet(); // uses contents before this edge's pushes
            if (ex_valid_0)
                push_entry(ex_pc_0, ex_taken_0, ex_kind_0, ex_target_0,
                           pd_taken_0, pd_target_0, pd_counter_0, ex_squash_0);
            if (ex_valid_1)
                push_entry(ex_pc_1, ex_taken_1, ex_kind_1, ex_target_1,
                           pd_taken_1, pd_target_1, pd_counter_1, ex_squash_1);
            model_count  = c_pc.size();
            head_waiting = (c_pc.size() == 1) && !(c_pc[0][0] || c_squash[0]);
            if (end_check && !checked)
                final_checks();
        end
    end

endmodule

// ==== tests/tb_top.sv ====
// testbench top with clock, reset, lfsr stimulus, dut and checker instances and watchdog
`timescale 1ns/1ps

module tb_top;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int STIM_CYCLES  = 3000;
    localparam int DRAIN_MARGIN = 300;
    localparam int IN_DELAY     = 1;
    localparam logic [31:0] LFSR_SEED = 32'd40;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic                         clk;
    logic                         rstn;
    logic                         ex_valid_0;
    logic [bpu_pkg::PC_W-1:0]     ex_pc_0;
    logic                         ex_taken_0;
    logic [bpu_pkg::KIND_W-1:0]   ex_kind_0;
    logic [bpu_pkg::PC_W-1:0]     ex_target_0;
    logic                         pd_taken_0;
    logic [bpu_pkg::PC_W-1:0]     pd_target_0;
    logic [1:0]                   pd_counter_0;
    logic                         ex_squash_0;
    logic                         ex_valid_1;
    logic [bpu_pkg::PC_W-1:0]     ex_pc_1;
    logic                         ex_taken_1;
    logic [bpu_pkg::KIND_W-1:0]   ex_kind_1;
    logic [bpu_pkg::PC_W-1:0]     ex_target_1;
    logic                         pd_taken_1;
    logic [bpu_pkg::PC_W-1:0]     pd_target_1;
    logic [1:0]                   pd_counter_1;
    logic                         ex_squash_1;
    logic [bpu_pkg::PC_W-1:0]     lookup_pc;
    logic                         upd_valid;
    logic [bpu_pkg::PC_W-1:0]     upd_pc;
    logic                         upd_taken;
    logic [bpu_pkg::KIND_W-1:0]   upd_kind;
    logic [bpu_pkg::PC_W-1:0]     upd_target;
    logic [1:0]                   upd_counter;
    logic                         upd_mispredict;
    logic [1:0]                   lookup_counter;
    logic                         lookup_hit;
    logic [bpu_pkg::PC_W-1:0]     lookup_target;
    logic [bpu_pkg::KIND_W-1:0]   lookup_kind;
    logic                         end_check;
    logic [31:0]                  mismatches;
    logic [31:0]                  other_errors;
    logic                         checked;
    logic [31:0]                  model_count;
    logic                         head_waiting;
    logic [31:0]                  lfsr;

    bpu_update_top dut (.*);

    tb_checker chk (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // small window so table entries alias and bit 9 flips the btb tag
    task automatic random_pc(output logic [bpu_pkg::PC_W-1:0] pc);
        logic [31:0] r;
        draw_bits(7, r);
        pc      = '0;
        pc[6:0] = r[6:0];
        draw_bits(1, r);
        pc[9]   = r[0];
    endtask

    task automatic random_instr(
        output logic [bpu_pkg::PC_W-1:0]   pc,
        output logic                       taken,
        output logic [bpu_pkg::KIND_W-1:0] kind,
        output logic [bpu_pkg::PC_W-1:0]   target,
        output logic                       p_taken,
        output logic [bpu_pkg::PC_W-1:0]   p_target,
        output logic [1:0]                 p_counter,
        output logic                       squash
    );
        logic [31:0] r;
        random_pc(pc);
        draw_bits(1, r);
        taken = r[0];
        draw_bits(3, r);
        kind = r[2:0] % 3'd6;
        draw_bits(bpu_pkg::PC_W, r);
        target = r[bpu_pkg::PC_W-1:0];
        draw_bits(1, r);
        p_taken = r[0];
        draw_bits(1, r);
        if (r[0]) begin
            p_target = target; // correct target half the time
        end else begin
            draw_bits(bpu_pkg::PC_W, r);
            p_target = r[bpu_pkg::PC_W-1:0];
        end
        draw_bits(2, r);
        p_counter = r[1:0];
        draw_bits(2, r);
        squash = (r[1:0] == 2'b00);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        int          room;
        int          idle;
        logic [31:0] r;
        logic        want0;
        logic        want1;
        lfsr      = LFSR_SEED;
        rstn      = 1'b0;
        end_check = 1'b0;
        lookup_pc = '0;
        {ex_valid_0, ex_pc_0, ex_taken_0, ex_kind_0, ex_target_0} = '0;
        {pd_taken_0, pd_target_0, pd_counter_0, ex_squash_0} = '0;
        {ex_valid_1, ex_pc_1, ex_taken_1, ex_kind_1, ex_target_1} = '0;
        {pd_taken_1, pd_target_1, pd_counter_1, ex_squash_1} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #IN_DELAY rstn = 1'b1;

        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge clk);
            #IN_DELAY;
            room = bpu_pkg::EXB_DEPTH - int'(model_count);
            draw_bits(2, r);
            want0 = (r[1:0] != 2'b00);
            draw_bits(2, r);
            want1 = (r[1:0] != 2'b00);
            if (room < 1) begin
                want0 = 1'b0;
                want1 = 1'b0;
            end else if (room < 2 && want0) begin
                want1 = 1'b0;
            end
            ex_valid_0 = want0;
            ex_valid_1 = want1;
            if (want0)
                random_instr(ex_pc_0, ex_taken_0, ex_kind_0, ex_target_0,
                             pd_taken_0, pd_target_0, pd_counter_0, ex_squash_0);
            if (want1)
                random_instr(ex_pc_1, ex_taken_1, ex_kind_1, ex_target_1,
                             pd_taken_1, pd_target_1, pd_counter_1, ex_squash_1);
            random_pc(lookup_pc);
        end

        // a squashed filler frees a lone waiting head during the drain
        idle = 0;
        while (idle < 4) begin
            @(posedge clk);
            #IN_DELAY;
            ex_valid_0 = 1'b0;
            ex_valid_1 = 1'b0;
            if (head_waiting) begin
                random_instr(ex_pc_0, ex_taken_0, ex_kind_0, ex_target_0,
                             pd_taken_0, pd_target_0, pd_counter_0, ex_squash_0);
                ex_squash_0 = 1'b1;
                ex_valid_0  = 1'b1;
            end
            random_pc(lookup_pc);
            idle = (!upd_valid && !head_waiting) ? idle + 1 : 0;
        end
        end_check = 1'b1;
        while (!checked) begin
            @(posedge clk);
            #IN_DELAY;
        end

        $display("mismatches %0d, other errors %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        #((RESET_CYCLES + STIM_CYCLES + DRAIN_MARGIN) * CLK_PERIOD);
        $display("timeout: run did not complete after %0d cycles",
                 RESET_CYCLES + STIM_CYCLES + DRAIN_MARGIN);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== sources.f ====
common/bpu_pkg.sv
hdl/pht.sv
hdl/btb.sv
ex_buffer/ex_buffer.sv
hdl/bpu_update_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_top
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
